//--- files.f
logic/gat_cfg_pkg.sv
logic/gat_types_pkg.sv
logic/gat_param_store.sv
logic/gat_feature_store.sv
logic/gat_spmm.sv
logic/gat_attention.sv
logic/gat_run_ctrl.sv
logic/gat_top.sv
verif/gat_checker.sv
verif/tb_gat_top.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tb_gat_top

out=$(./obj_dir/Vtb_gat_top 2>&1) || true
echo "$out"

if echo "$out" | grep -q "SIMULATION PASSED"; then
  exit 0
fi
exit 1

//--- verif/tb_gat_top.sv
`timescale 1ns/10ps

module tb_gat_top
  import gat_cfg_pkg::*;
  import gat_types_pkg::*;
();

  localparam int N_AW           = $clog2(NODE_DEPTH_DEF);
  localparam int CNT_W          = $clog2(NODE_DEPTH_DEF + 1);
  localparam int TIMEOUT_CYCLES = 2 * (32 * 22 + 64) + 2000;

  logic               clk;
  logic               rst_n;
  feat_load_t         feat_load;
  param_load_t        param_load;
  logic [CNT_W-1:0]   run_nodes;
  logic               start_req;
  logic [N_AW-1:0]    rd_addr;
  logic               start_ack;
  logic [SCORE_W-1:0] rd_data;

  // Reference model state
  int w_mdl     [F_IN][F_OUT];
  int a_src_mdl [F_OUT];
  int a_dst_mdl [F_OUT];
  int h_val     [H_DEPTH_DEF];
  int h_col     [H_DEPTH_DEF];
  int row_len   [NODE_DEPTH_DEF];
  int sub_nodes [NODE_DEPTH_DEF];
  bit is_head   [NODE_DEPTH_DEF];
  int wh_mdl    [NODE_DEPTH_DEF][F_OUT];
  int score_mdl [NODE_DEPTH_DEF];
  int num_nodes;
  int num_entries;
  int cycle_cnt = 0;

  gat_top #(
    .H_DEPTH    (H_DEPTH_DEF),
    .NODE_DEPTH (NODE_DEPTH_DEF)
  ) u_gat_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .feat_load_i  (feat_load),
    .param_load_i (param_load),
    .run_nodes_i  (run_nodes),
    .start_req_i  (start_req),
    .rd_addr_i    (rd_addr),
    .start_ack_o  (start_ack),
    .rd_data_o    (rd_data)
  );

  bind gat_run_ctrl gat_checker u_checker (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_req_i (start_req_i),
    .start_ack_i (start_ack_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("SIMULATION FAILED");
      $fatal(1, "cycle limit reached");
    end
  end

  // ========================================
  // Compare tasks
  // ========================================
  task automatic check_score(input logic [SCORE_W-1:0] got, input logic [SCORE_W-1:0] exp,
                             input int node);
    if (got !== exp) begin
      $display("mismatch at %0t: score of node %0d is %0d, expected %0d",
               $time, node, $signed(got), $signed(exp));
      $display("SIMULATION FAILED");
      $fatal(1, "score compare failed");
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
      $display("SIMULATION FAILED");
      $fatal(1, "handshake compare failed");
    end
  endtask

  function automatic int rand_byte();
    logic signed [DATA_W-1:0] b;
    b = DATA_W'($urandom);
    return int'(b);
  endfunction

  // ========================================
  // Stimulus generation and loading
  // ========================================
  task automatic gen_graph();
    int node;
    int size;
    int sub_idx;
    int used;
    num_nodes = $urandom_range(24, 8);
    node      = 0;
    sub_idx   = 0;
    used      = 0;
    while (node < num_nodes) begin
      // Subgraph 1 holds a zero-length member, every third one is single
      if (sub_idx == 1) begin
        size = 3;
      end else if (sub_idx % 3 == 0) begin
        size = 1;
      end else begin
        size = $urandom_range(6, 1);
      end
      if (size > num_nodes - node) begin
        size = num_nodes - node;
      end
      for (int m = 0; m < size; m++) begin
        is_head[node]   = (m == 0);
        sub_nodes[node] = (m == 0) ? size : int'($urandom_range(15, 0));
        row_len[node]   = (sub_idx == 1 && m == 1) ? 0 : int'($urandom_range(6, 0));
        if (row_len[node] > H_DEPTH_DEF - used) begin
          row_len[node] = H_DEPTH_DEF - used;
        end
        for (int k = 0; k < row_len[node]; k++) begin
          h_val[used + k] = rand_byte();
          h_col[used + k] = $urandom_range(F_IN - 1, 0);
        end
        used = used + row_len[node];
        node = node + 1;
      end
      sub_idx = sub_idx + 1;
    end
    num_entries = used;
  endtask

  task automatic gen_params(input bit neg_att);
    for (int c = 0; c < F_IN; c++) begin
      for (int f = 0; f < F_OUT; f++) begin
        w_mdl[c][f] = rand_byte();
      end
    end
    for (int f = 0; f < F_OUT; f++) begin
      a_src_mdl[f] = neg_att ? -int'($urandom_range(128, 1)) : rand_byte();
      a_dst_mdl[f] = neg_att ? -int'($urandom_range(128, 1)) : rand_byte();
    end
  endtask

  task automatic load_params();
    for (int c = 0; c < F_IN; c++) begin
      for (int f = 0; f < F_OUT; f++) begin
        @(negedge clk);
        param_load.en     = 1'b1;
        param_load.is_att = 1'b0;
        param_load.addr   = LOAD_ADDR_W'(c * F_OUT + f);
        param_load.val    = DATA_W'(w_mdl[c][f]);
      end
    end
    // Source half first, then destination half
    for (int i = 0; i < 2 * F_OUT; i++) begin
      @(negedge clk);
      param_load.is_att = 1'b1;
      param_load.addr   = LOAD_ADDR_W'(i);
      param_load.val    = DATA_W'((i < F_OUT) ? a_src_mdl[i] : a_dst_mdl[i - F_OUT]);
    end
    @(negedge clk);
    param_load = '0;
  endtask

  task automatic load_features();
    for (int i = 0; i < num_entries; i++) begin
      @(negedge clk);
      feat_load            = '0;
      feat_load.en         = 1'b1;
      feat_load.is_node    = TGT_H;
      feat_load.addr       = LOAD_ADDR_W'(i);
      feat_load.word.h.val = DATA_W'(h_val[i]);
      feat_load.word.h.col = COL_W'(h_col[i]);
    end
    for (int n = 0; n < num_nodes; n++) begin
      @(negedge clk);
      feat_load                     = '0;
      feat_load.en                  = 1'b1;
      feat_load.is_node             = TGT_NODE;
      feat_load.addr                = LOAD_ADDR_W'(n);
      feat_load.word.node.row_len   = ROW_LEN_W'(row_len[n]);
      feat_load.word.node.sub_nodes = SUB_W'(sub_nodes[n]);
      feat_load.word.node.head      = is_head[n];
      feat_load.word.node.spare     = 2'($urandom);
    end
    @(negedge clk);
    feat_load = '0;
  endtask

  // ========================================
  // Reference model
  // ========================================
  task automatic build_model();
    int ptr;
    int cur_head;
    int sum;
    ptr = 0;
    for (int n = 0; n < num_nodes; n++) begin
      for (int f = 0; f < F_OUT; f++) begin
        wh_mdl[n][f] = 0;
      end
      for (int k = 0; k < row_len[n]; k++) begin
        for (int f = 0; f < F_OUT; f++) begin
          wh_mdl[n][f] = wh_mdl[n][f] + h_val[ptr] * w_mdl[h_col[ptr]][f];
        end
        ptr = ptr + 1;
      end
    end
    cur_head = 0;
    for (int n = 0; n < num_nodes; n++) begin
      if (is_head[n]) begin
        cur_head = n;
      end
      sum = 0;
      for (int f = 0; f < F_OUT; f++) begin
        sum = sum + a_src_mdl[f] * wh_mdl[cur_head][f] + a_dst_mdl[f] * wh_mdl[n][f];
      end
      // LeakyReLU
      score_mdl[n] = (sum < 0) ? (sum >>> LRELU_SHIFT) : sum;
    end
  endtask

  task automatic run_and_check();
    check_bit(start_ack, 1'b0, "start_ack before request");
    run_nodes = CNT_W'(num_nodes);
    start_req = 1'b1;
    @(negedge clk);
    check_bit(start_ack, 1'b0, "start_ack one cycle after request");
    while (start_ack !== 1'b1) begin
      @(negedge clk);
    end
    for (int n = 0; n < num_nodes; n++) begin
      rd_addr = N_AW'(n);
      @(negedge clk);
      check_score(rd_data, SCORE_W'(score_mdl[n]), n);
    end
    check_bit(start_ack, 1'b1, "start_ack during readback");
    start_req = 1'b0;
    repeat (2) @(negedge clk);
    check_bit(start_ack, 1'b0, "start_ack after request drop");
  endtask

  initial begin
    void'($urandom(18));
    rst_n      = 1'b0;
    feat_load  = '0;
    param_load = '0;
    run_nodes  = '0;
    start_req  = 1'b0;
    rd_addr    = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_bit(start_ack, 1'b0, "start_ack after reset");

    gen_graph();
    gen_params(1'b0);
    load_params();
    load_features();
    build_model();
    run_and_check();

    // Same graph, new weights and all-negative attention bytes
    gen_params(1'b1);
    load_params();
    build_model();
    run_and_check();

    if (u_gat_top.u_run_ctrl.u_checker.fail_cnt == 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      $display("handshake assertions failed %0d times",
               u_gat_top.u_run_ctrl.u_checker.fail_cnt);
      $display("SIMULATION FAILED");
      $fatal(1, "assertion failures");
    end
  end

endmodule

//--- verif/gat_checker.sv
`timescale 1ns/10ps

module gat_checker (
  input logic clk,
  input logic rst_n,
  input logic start_req_i,
  input logic start_ack_i
);

  int fail_cnt = 0;

  // ========================================
  // Start handshake
  // ========================================
  ack_rise_with_req: assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(start_ack_i) |-> start_req_i
  ) else begin
    $error("start_ack rose while start_req was low");
    fail_cnt = fail_cnt + 1;
  end

  // Ack may only drop once the request was seen low
  ack_fall_after_req: assert property (
    @(posedge clk) disable iff (!rst_n)
    $fell(start_ack_i) |-> !$past(start_req_i)
  ) else begin
    $error("start_ack fell while start_req was still high");
    fail_cnt = fail_cnt + 1;
  end

  ack_low_out_of_reset: assert property (
    @(posedge clk)
    $rose(rst_n) |-> !start_ack_i
  ) else begin
    $error("start_ack high in the first cycle after reset");
    fail_cnt = fail_cnt + 1;
  end

endmodule

//--- logic/gat_top.sv
`timescale 1ns/10ps

module gat_top
  import gat_cfg_pkg::*;
  import gat_types_pkg::*;
#(
  parameter int  H_DEPTH    = H_DEPTH_DEF,
  parameter int  NODE_DEPTH = NODE_DEPTH_DEF,
  localparam int H_AW       = $clog2(H_DEPTH),
  localparam int N_AW       = $clog2(NODE_DEPTH),
  localparam int CNT_W      = $clog2(NODE_DEPTH + 1)
) (
  input  logic               clk,
  input  logic               rst_n,
  input  feat_load_t         feat_load_i,
  input  param_load_t        param_load_i,
  input  logic [CNT_W-1:0]   run_nodes_i,
  input  logic               start_req_i,
  input  logic [N_AW-1:0]    rd_addr_i,
  output logic               start_ack_o,
  output logic [SCORE_W-1:0] rd_data_o
);

  logic [F_IN-1:0][F_OUT-1:0][DATA_W-1:0] weights;
  logic [F_OUT-1:0][DATA_W-1:0]           att_src;
  logic [F_OUT-1:0][DATA_W-1:0]           att_dst;
  logic [H_AW-1:0]                        h_addr;
  logic [N_AW-1:0]                        node_addr;
  h_entry_t                               h_entry;
  node_info_t                             node_info;
  wh_row_t                                wh_row;
  logic                                   wh_vld;
  logic                                   spmm_start;
  logic                                   spmm_done;
  logic                                   att_start;
  logic                                   att_done;

  // ========================================
  // Host-loaded storage
  // ========================================
  gat_param_store u_param_store (
    .clk          (clk),
    .rst_n        (rst_n),
    .param_load_i (param_load_i),
    .weights_o    (weights),
    .att_src_o    (att_src),
    .att_dst_o    (att_dst)
  );

  gat_feature_store #(
    .H_DEPTH    (H_DEPTH),
    .NODE_DEPTH (NODE_DEPTH)
  ) u_feature_store (
    .clk         (clk),
    .feat_load_i (feat_load_i),
    .h_addr_i    (h_addr),
    .h_entry_o   (h_entry),
    .node_addr_i (node_addr),
    .node_info_o (node_info)
  );

  // ========================================
  // Engines and sequencing
  // ========================================
  gat_spmm #(
    .H_DEPTH    (H_DEPTH),
    .NODE_DEPTH (NODE_DEPTH)
  ) u_spmm (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (spmm_start),
    .run_nodes_i (run_nodes_i),
    .h_addr_o    (h_addr),
    .node_addr_o (node_addr),
    .h_entry_i   (h_entry),
    .node_info_i (node_info),
    .weights_i   (weights),
    .wh_row_o    (wh_row),
    .wh_vld_o    (wh_vld),
    .done_o      (spmm_done)
  );

  gat_attention #(
    .NODE_DEPTH (NODE_DEPTH)
  ) u_attention (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (att_start),
    .run_nodes_i (run_nodes_i),
    .wh_row_i    (wh_row),
    .wh_vld_i    (wh_vld),
    .att_src_i   (att_src),
    .att_dst_i   (att_dst),
    .rd_addr_i   (rd_addr_i),
    .rd_data_o   (rd_data_o),
    .done_o      (att_done)
  );

  gat_run_ctrl u_run_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .start_req_i  (start_req_i),
    .start_ack_o  (start_ack_o),
    .spmm_start_o (spmm_start),
    .att_start_o  (att_start),
    .spmm_done_i  (spmm_done),
    .att_done_i   (att_done)
  );

endmodule

//--- logic/gat_run_ctrl.sv
`timescale 1ns/10ps

module gat_run_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic start_req_i,
  output logic start_ack_o,
  output logic spmm_start_o,
  output logic att_start_o,
  input  logic spmm_done_i,
  input  logic att_done_i
);

  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_WH   = 2'd1;
  localparam logic [1:0] S_ATT  = 2'd2;
  localparam logic [1:0] S_ACK  = 2'd3;

  logic [1:0] state;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state        <= S_IDLE;
      start_ack_o  <= 1'b0;
      spmm_start_o <= 1'b0;
      att_start_o  <= 1'b0;
    end else begin
      spmm_start_o <= 1'b0;
      att_start_o  <= 1'b0;
      case (state)
        S_IDLE: begin
          if (start_req_i) begin
            spmm_start_o <= 1'b1;
            state        <= S_WH;
          end
        end
        S_WH: begin
          if (spmm_done_i) begin
            att_start_o <= 1'b1;
            state       <= S_ATT;
          end
        end
        S_ATT: begin
          if (att_done_i) begin
            start_ack_o <= 1'b1;
            state       <= S_ACK;
          end
        end
        // Hold ack until the host drops its request
        default: begin
          if (!start_req_i) begin
            start_ack_o <= 1'b0;
            state       <= S_IDLE;
          end
        end
      endcase
    end
  end

endmodule

//--- logic/gat_attention.sv
`timescale 1ns/10ps

module gat_attention
  import gat_cfg_pkg::*;
  import gat_types_pkg::*;
#(
  parameter int  NODE_DEPTH = NODE_DEPTH_DEF,
  localparam int N_AW       = $clog2(NODE_DEPTH),
  localparam int CNT_W      = $clog2(NODE_DEPTH + 1)
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        start_i,
  input  logic [CNT_W-1:0]            run_nodes_i,
  input  wh_row_t                     wh_row_i,
  input  logic                        wh_vld_i,
  input  logic [F_OUT-1:0][DATA_W-1:0] att_src_i,
  input  logic [F_OUT-1:0][DATA_W-1:0] att_dst_i,
  input  logic [N_AW-1:0]             rd_addr_i,
  output logic [SCORE_W-1:0]          rd_data_o,
  output logic                        done_o
);

  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_RD   = 2'd1;
  localparam logic [1:0] S_CALC = 2'd2;

  logic [1:0]                state;
  logic [N_AW-1:0]           idx;
  logic [N_AW-1:0]           node_last;
  logic [SUB_W-1:0]          mem_left;
  wh_row_t                   wh_mem    [NODE_DEPTH];
  logic [SCORE_W-1:0]        score_mem [NODE_DEPTH];
  wh_row_t                   rd_row;
  logic                      start_sub;
  logic signed [SCORE_W-1:0] src_dot;
  logic signed [SCORE_W-1:0] dst_dot;
  logic signed [SCORE_W-1:0] src_q;
  logic signed [SCORE_W-1:0] sum;
  logic signed [SCORE_W-1:0] score;

  // New subgraph on a head flag or when the member count runs out
  assign start_sub = rd_row.head || (mem_left == '0);

  always_comb begin
    src_dot = '0;
    dst_dot = '0;
    for (int f = 0; f < F_OUT; f++) begin
      src_dot = src_dot + $signed(att_src_i[f]) * $signed(rd_row.wh[f]);
      dst_dot = dst_dot + $signed(att_dst_i[f]) * $signed(rd_row.wh[f]);
    end
    sum   = (start_sub ? src_dot : src_q) + dst_dot;
    // LeakyReLU
    score = sum[SCORE_W-1] ? (sum >>> LRELU_SHIFT) : sum;
  end

  // ========================================
  // Member walk, two cycles per node
  // ========================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= S_IDLE;
      idx       <= '0;
      node_last <= '0;
      mem_left  <= '0;
      done_o    <= 1'b0;
    end else begin
      done_o <= 1'b0;
      case (state)
        S_IDLE: begin
          if (start_i) begin
            idx       <= '0;
            mem_left  <= '0;
            node_last <= N_AW'(run_nodes_i - 1'b1);
            if (run_nodes_i == '0) begin
              done_o <= 1'b1;
            end else begin
              state <= S_RD;
            end
          end
        end
        S_RD: state <= S_CALC;
        S_CALC: begin
          if (start_sub) begin
            mem_left <= (rd_row.sub_nodes == '0) ? '0 : rd_row.sub_nodes - 1'b1;
          end else begin
            mem_left <= mem_left - 1'b1;
          end
          if (idx == node_last) begin
            state  <= S_IDLE;
            done_o <= 1'b1;
          end else begin
            idx   <= idx + 1'b1;
            state <= S_RD;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wh_vld_i) begin
      wh_mem[wh_row_i.node] <= wh_row_i;
    end
    if (state == S_RD) begin
      rd_row <= wh_mem[idx];
    end
    if (state == S_CALC) begin
      score_mem[idx] <= score;
      if (start_sub) begin
        src_q <= src_dot;
      end
    end
    rd_data_o <= score_mem[rd_addr_i];
  end

endmodule

//--- logic/gat_spmm.sv
`timescale 1ns/10ps

module gat_spmm
  import gat_cfg_pkg::*;
  import gat_types_pkg::*;
#(
  parameter int  H_DEPTH    = H_DEPTH_DEF,
  parameter int  NODE_DEPTH = NODE_DEPTH_DEF,
  localparam int H_AW       = $clog2(H_DEPTH),
  localparam int N_AW       = $clog2(NODE_DEPTH),
  localparam int CNT_W      = $clog2(NODE_DEPTH + 1)
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   start_i,
  input  logic [CNT_W-1:0]                       run_nodes_i,
  output logic [H_AW-1:0]                        h_addr_o,
  output logic [N_AW-1:0]                        node_addr_o,
  input  h_entry_t                               h_entry_i,
  input  node_info_t                             node_info_i,
  input  logic [F_IN-1:0][F_OUT-1:0][DATA_W-1:0] weights_i,
  output wh_row_t                                wh_row_o,
  output logic                                   wh_vld_o,
  output logic                                   done_o
);

  localparam logic [2:0] S_IDLE  = 3'd0;
  localparam logic [2:0] S_INFO  = 3'd1;
  localparam logic [2:0] S_LATCH = 3'd2;
  localparam logic [2:0] S_MAC   = 3'd3;
  localparam logic [2:0] S_EMIT  = 3'd4;

  logic [2:0]                  state;
  logic [N_AW-1:0]             node_cnt;
  logic [N_AW-1:0]             node_last;
  logic [H_AW-1:0]             h_ptr;
  logic [ROW_LEN_W-1:0]        ent_left;
  logic [F_OUT-1:0][WH_W-1:0]  acc;
  logic                        row_head;
  logic [SUB_W-1:0]            row_sub;
  logic signed [2*DATA_W-1:0]  prod [F_OUT];

  assign h_addr_o    = h_ptr;
  assign node_addr_o = node_cnt;

  // ========================================
  // Node walk
  // ========================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= S_IDLE;
      node_cnt  <= '0;
      node_last <= '0;
      h_ptr     <= '0;
      ent_left  <= '0;
      done_o    <= 1'b0;
    end else begin
      done_o <= 1'b0;
      case (state)
        S_IDLE: begin
          if (start_i) begin
            node_cnt  <= '0;
            h_ptr     <= '0;
            node_last <= N_AW'(run_nodes_i - 1'b1);
            if (run_nodes_i == '0) begin
              done_o <= 1'b1;
            end else begin
              state <= S_INFO;
            end
          end
        end
        S_INFO: state <= S_LATCH;
        S_LATCH: begin
          ent_left <= node_info_i.row_len;
          if (node_info_i.row_len == '0) begin
            state <= S_EMIT;
          end else begin
            // First entry address already issued
            h_ptr <= h_ptr + 1'b1;
            state <= S_MAC;
          end
        end
        S_MAC: begin
          ent_left <= ent_left - 1'b1;
          if (ent_left == ROW_LEN_W'(1)) begin
            state <= S_EMIT;
          end else begin
            h_ptr <= h_ptr + 1'b1;
          end
        end
        S_EMIT: begin
          node_cnt <= node_cnt + 1'b1;
          if (node_cnt == node_last) begin
            state  <= S_IDLE;
            done_o <= 1'b1;
          end else begin
            state <= S_INFO;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Entry value times row col of W
  always_comb begin
    for (int f = 0; f < F_OUT; f++) begin
      prod[f] = $signed(h_entry_i.val) * $signed(weights_i[h_entry_i.col][f]);
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_LATCH) begin
      acc      <= '0;
      row_head <= node_info_i.head;
      row_sub  <= node_info_i.sub_nodes;
    end else if (state == S_MAC) begin
      for (int f = 0; f < F_OUT; f++) begin
        acc[f] <= $signed(acc[f]) + prod[f];
      end
    end
  end

  assign wh_row_o.wh        = acc;
  assign wh_row_o.head      = row_head;
  assign wh_row_o.sub_nodes = row_sub;
  assign wh_row_o.node      = node_cnt;
  assign wh_vld_o           = (state == S_EMIT);

endmodule

//--- logic/gat_feature_store.sv
`timescale 1ns/10ps

module gat_feature_store
  import gat_types_pkg::*;
#(
  parameter int  H_DEPTH    = 128,
  parameter int  NODE_DEPTH = 32,
  localparam int H_AW       = $clog2(H_DEPTH),
  localparam int N_AW       = $clog2(NODE_DEPTH)
) (
  input  logic            clk,
  input  feat_load_t      feat_load_i,
  input  logic [H_AW-1:0] h_addr_i,
  output h_entry_t        h_entry_o,
  input  logic [N_AW-1:0] node_addr_i,
  output node_info_t      node_info_o
);

  // ========================================
  // Storage
  // ========================================
  h_entry_t   h_mem    [H_DEPTH];
  node_info_t node_mem [NODE_DEPTH];

  logic wr_node;
  logic wr_h;

  assign wr_node = feat_load_i.en && (feat_load_i.is_node == TGT_NODE);
  assign wr_h    = feat_load_i.en && (feat_load_i.is_node == TGT_H);

  // Host word decoded as node info or as a sparse entry
  always_ff @(posedge clk) begin
    if (wr_node) begin
      node_mem[feat_load_i.addr[N_AW-1:0]] <= feat_load_i.word.node;
    end
    if (wr_h) begin
      h_mem[feat_load_i.addr[H_AW-1:0]] <= feat_load_i.word.h;
    end
  end

  // ========================================
  // Read ports, one cycle latency
  // ========================================
  always_ff @(posedge clk) begin
    h_entry_o <= h_mem[h_addr_i];
  end

  always_ff @(posedge clk) begin
    node_info_o <= node_mem[node_addr_i];
  end

endmodule

//--- logic/gat_param_store.sv
`timescale 1ns/10ps

module gat_param_store
  import gat_cfg_pkg::*;
  import gat_types_pkg::*;
(
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  param_load_t                           param_load_i,
  output logic [F_IN-1:0][F_OUT-1:0][DATA_W-1:0] weights_o,
  output logic [F_OUT-1:0][DATA_W-1:0]          att_src_o,
  output logic [F_OUT-1:0][DATA_W-1:0]          att_dst_o
);

  localparam int W_COL_W = $clog2(F_OUT);
  localparam int W_ROW_W = $clog2(F_IN);

  logic [W_ROW_W-1:0] w_row;
  logic [W_COL_W-1:0] w_col;
  logic               att_is_dst;

  // Weight index is col * F_OUT + feature
  assign w_row      = param_load_i.addr[W_COL_W +: W_ROW_W];
  assign w_col      = param_load_i.addr[W_COL_W-1:0];
  // Upper half of the attention vector is the destination part
  assign att_is_dst = param_load_i.addr[W_COL_W];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      weights_o <= '0;
      att_src_o <= '0;
      att_dst_o <= '0;
    end else if (param_load_i.en) begin
      if (!param_load_i.is_att) begin
        weights_o[w_row][w_col] <= param_load_i.val;
      end else if (att_is_dst) begin
        att_dst_o[w_col] <= param_load_i.val;
      end else begin
        att_src_o[w_col] <= param_load_i.val;
      end
    end
  end

endmodule

//--- logic/gat_types_pkg.sv
package gat_types_pkg;
  import gat_cfg_pkg::*;

  // Which feature memory a host word goes to
  typedef enum logic {
    TGT_H    = 1'b0,
    TGT_NODE = 1'b1
  } feat_tgt_e;

  typedef struct packed {
    logic signed [DATA_W-1:0] val;
    logic [COL_W-1:0]         col;
  } h_entry_t;

  typedef struct packed {
    logic [1:0]           spare;
    logic                 head;
    logic [SUB_W-1:0]     sub_nodes;
    logic [ROW_LEN_W-1:0] row_len;
  } node_info_t;

  // Same 12-bit host word, two meanings
  typedef union packed {
    h_entry_t   h;
    node_info_t node;
  } load_word_u;

  typedef struct packed {
    logic                   en;
    logic                   is_node;
    logic [LOAD_ADDR_W-1:0] addr;
    load_word_u             word;
  } feat_load_t;

  typedef struct packed {
    logic                     en;
    logic                     is_att;
    logic [LOAD_ADDR_W-1:0]   addr;
    logic signed [DATA_W-1:0] val;
  } param_load_t;

  typedef struct packed {
    logic [F_OUT-1:0][WH_W-1:0]          wh;
    logic                                head;
    logic [SUB_W-1:0]                    sub_nodes;
    logic [$clog2(NODE_DEPTH_DEF)-1:0]   node;
  } wh_row_t;

endpackage

//--- logic/gat_cfg_pkg.sv
package gat_cfg_pkg;

  // ========================================
  // Datapath widths
  // ========================================
  localparam int DATA_W      = 8;
  localparam int WH_W        = 20;
  localparam int SCORE_W     = 32;
  localparam int LRELU_SHIFT = 3;

  // Layer shape
  localparam int F_IN  = 16;
  localparam int F_OUT = 4;

  // Sparse matrix and node-info fields
  localparam int COL_W     = 4;
  localparam int ROW_LEN_W = 5;
  localparam int SUB_W     = 4;

  localparam int H_DEPTH_DEF    = 128;
  localparam int NODE_DEPTH_DEF = 32;
  localparam int LOAD_ADDR_W    = $clog2(H_DEPTH_DEF);

endpackage
